/* pcie_cfg_regs.f */
design/cfg_pkg.sv
design/cfg_sync_fifo.sv
design/cfg_cmd_decode.sv
design/cfg_reg_file.sv
design/cfg_mgmt_seq.sv
design/pcie_cfg_regs.sv
testbench/tb_pcie_cfg_regs.sv

/* Makefile */
TOP := tb_pcie_cfg_regs

.PHONY: all lint clean

# Build, run, and pass only when the pass line shows up
all: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

obj_dir/V$(TOP): pcie_cfg_regs.f $(wildcard design/*.sv testbench/*.sv)
	verilator --binary --timing -j 0 -f pcie_cfg_regs.f --top-module $(TOP)

lint:
	verilator --lint-only --timing -f pcie_cfg_regs.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* testbench/tb_pcie_cfg_regs.sv */
// Testbench for the PCIe configuration control block
// Runs a table of commands through the DUT, answers the management
// port with a model of random latency and checks every response
`timescale 1ns/10ps
`default_nettype none

module tb_pcie_cfg_regs;

    localparam int          KIND_WRITE = 0;   // No response
    localparam int          KIND_READ  = 1;
    localparam int          KIND_POLL  = 2;   // Re-read until result valid
    localparam int          KIND_WRCHK = 3;   // Port model's write record
    localparam int          KIND_BURST = 4;
    localparam int          MAX_ROWS   = 80;
    localparam logic [15:0] PCIE_ID    = 16'h1A2B;

    logic        clk_pcie = 1'b0;
    logic        rst;
    logic        i_cmd_valid;
    logic [63:0] i_cmd_data;
    logic        o_cmd_ready;
    logic        o_rsp_valid;
    logic [31:0] o_rsp_data;
    logic        i_rsp_rd_en;
    logic [15:0] i_pcie_id;
    logic        o_cfg_mgmt_rd_en;
    logic        o_cfg_mgmt_wr_en;
    logic        mgmt_done = 1'b0;
    logic [31:0] mgmt_do = 32'h0;
    logic [31:0] o_cfg_mgmt_di;
    logic [9:0]  o_cfg_mgmt_dwaddr;
    logic [3:0]  o_cfg_mgmt_byte_en;
    logic        o_cfg_mgmt_wr_readonly;
    logic        o_cfg_mgmt_wr_rw1c_as_rw;

    // ----------------------------------------
    // Stimulus table
    // ----------------------------------------
    string       row_name [MAX_ROWS];
    int          row_kind [MAX_ROWS];
    logic [63:0] row_cmd  [MAX_ROWS];
    logic [31:0] row_exp  [MAX_ROWS];
    logic [31:0] row_aux  [MAX_ROWS];   // Byte enables, rw1c, readonly, dword address
    int          row_count = 0;

    integer      seed = 47;
    int          pending = 0;           // Model saw an enable
    int          wait_left = 0;
    int          wr_count = 0;
    logic [31:0] wr_data = 32'h0;
    logic [31:0] wr_ctrl = 32'h0;

    int          cycle_count = 0;
    int          cycle_limit = 0;
    int          fail_count = 0;
    int          saw_not_ready = 0;
    int          burst_first;
    int          burst_end;
    int          push_idx;
    int          pop_idx;
    int          r;
    logic [31:0] got_word;
    logic [15:0] rd_data;

    pcie_cfg_regs #(
        .CMD_DEPTH_LOG2(cfg_pkg::FIFO_DEPTH_LOG2),
        .RSP_DEPTH_LOG2(cfg_pkg::FIFO_DEPTH_LOG2)
    ) pcie_cfg_regs_inst (
        .clk_pcie(clk_pcie), .rst(rst), .i_cmd_valid(i_cmd_valid),
        .i_cmd_data(i_cmd_data), .o_cmd_ready(o_cmd_ready), .o_rsp_valid(o_rsp_valid),
        .o_rsp_data(o_rsp_data), .i_rsp_rd_en(i_rsp_rd_en), .i_pcie_id(i_pcie_id),
        .o_cfg_mgmt_rd_en(o_cfg_mgmt_rd_en), .o_cfg_mgmt_wr_en(o_cfg_mgmt_wr_en),
        .i_cfg_mgmt_rd_wr_done(mgmt_done), .i_cfg_mgmt_do(mgmt_do),
        .o_cfg_mgmt_di(o_cfg_mgmt_di), .o_cfg_mgmt_dwaddr(o_cfg_mgmt_dwaddr),
        .o_cfg_mgmt_byte_en(o_cfg_mgmt_byte_en),
        .o_cfg_mgmt_wr_readonly(o_cfg_mgmt_wr_readonly),
        .o_cfg_mgmt_wr_rw1c_as_rw(o_cfg_mgmt_wr_rw1c_as_rw)
    );

    always #10 clk_pcie = ~clk_pcie;

    // Type bit 12 reads and bit 13 writes with mask and value byte-swapped
    function automatic logic [63:0] make_cmd(input logic wr, input logic [15:0] addr,
                                             input logic [15:0] mask,
                                             input logic [15:0] value);
        return {value[7:0], value[15:8], mask[7:0], mask[15:8], addr,
                2'b00, wr, ~wr, 12'h000};
    endfunction

    function automatic logic [31:0] rsp_of(input logic [15:0] addr, input logic [15:0] data);
        return {addr, data[7:0], data[15:8]};
    endfunction

    task add_row(input string name, input int kind, input logic [63:0] cmd,
                 input logic [31:0] exp, input logic [31:0] aux);
        begin
            row_name[row_count] = name;
            row_kind[row_count] = kind;
            row_cmd[row_count]  = cmd;
            row_exp[row_count]  = exp;
            row_aux[row_count]  = aux;
            row_count           = row_count + 1;
        end
    endtask

    task add_read(input string name, input int kind, input logic [15:0] addr,
                  input logic [15:0] data);
        add_row(name, kind, make_cmd(1'b0, addr, 16'h0, 16'h0), rsp_of(addr, data), 32'h0);
    endtask

    task add_write(input string name, input logic [15:0] addr, input logic [15:0] mask,
                   input logic [15:0] value);
        add_row(name, KIND_WRITE, make_cmd(1'b1, addr, mask, value), 32'h0, 32'h0);
    endtask

    task build_table;
        int          i;
        logic [15:0] addr;
        logic [15:0] data;
        begin
            add_read("rw_magic", KIND_READ, 16'h8000, 16'h6745);
            add_read("ro_magic", KIND_READ, 16'h0000, 16'h2301);
            add_read("rw_byte_count", KIND_READ, 16'h8004, 16'h0010);
            add_read("ro_byte_count", KIND_READ, 16'h0004, 16'h0010);
            add_read("rw_byte_en_reset", KIND_READ, 16'h800C, 16'hF000);
            add_read("ro_pcie_id", KIND_READ, 16'h000E, PCIE_ID);
            // Masked writes into the management write data
            add_write("di_low_full", 16'h8008, 16'hFFFF, 16'h1234);
            add_read("di_low_full_rd", KIND_READ, 16'h8008, 16'h1234);
            add_write("di_low_masked", 16'h8008, 16'h0FF0, 16'hABCD);
            add_read("di_low_masked_rd", KIND_READ, 16'h8008, 16'h1BC4);
            add_write("di_high_full", 16'h800A, 16'hFFFF, 16'h5678);
            add_read("di_high_full_rd", KIND_READ, 16'h800A, 16'h5678);
            // Writes to the RO map land nowhere and out-of-range reads give zero
            add_write("ro_write", 16'h0000, 16'hFFFF, 16'hFFFF);
            add_read("rw_magic_kept", KIND_READ, 16'h8000, 16'h6745);
            add_read("rw_past_end", KIND_READ, 16'h8010, 16'h0000);
            add_read("ro_past_end", KIND_READ, 16'h0020, 16'h0000);
            add_read("far_addr", KIND_READ, 16'h7000, 16'h0000);
            // Management read of dword 0x123
            add_write("rd_dwaddr", 16'h800C, 16'hFFFF, 16'hF123);
            add_write("rd_req_set", 16'h8002, 16'h0001, 16'h0001);
            add_read("rd_result_addr", KIND_POLL, 16'h000C, 16'hF923);
            add_read("rd_result_lo", KIND_READ, 16'h0008, 16'h0123);
            add_read("rd_result_hi", KIND_READ, 16'h000A, 16'hA500);
            add_read("rd_req_cleared", KIND_READ, 16'h8002, 16'h0000);
            // Management write of dword 0x045 with byte enables 4'h5 and write-readonly set
            add_write("wr_dwaddr", 16'h800C, 16'hFFFF, 16'h5445);
            add_write("wr_req_set", 16'h8002, 16'h0002, 16'h0002);
            add_read("wr_result_addr", KIND_POLL, 16'h000C, 16'h5845);
            add_row("wr_port", KIND_WRCHK, 64'h0, 32'h5678_1BC4, 32'h0000_5445);
            // More reads than both FIFOs hold with echoed addresses to keep order visible
            for (i = 0; i < 34; i = i + 1)
            begin
                if (i % 2 == 0)
                begin
                    addr = 16'h0100 + 16'(i);
                    data = 16'h0000;
                end
                else if (i % 3 == 0)
                begin
                    addr = 16'h8000;
                    data = 16'h6745;
                end
                else if (i % 3 == 1)
                begin
                    addr = 16'h000E;
                    data = PCIE_ID;
                end
                else
                begin
                    addr = 16'h8008;
                    data = 16'h1BC4;
                end
                add_read($sformatf("burst_%0d", i), KIND_BURST, addr, data);
            end
        end
    endtask

    task check_value(input string test_name, input logic [31:0] expected,
                     input logic [31:0] actual);
        begin
            if (actual !== expected)
            begin
                fail_count = fail_count + 1;
                $display("CHECK FAILED %s expected %h actual %h", test_name, expected, actual);
                $display("CHECKS FAILED");
                $fatal(1, "Stopped at first mismatch");
            end
        end
    endtask

    // Called on a falling edge and returns on the falling edge after acceptance
    task push_cmd(input logic [63:0] cmd);
        begin
            i_cmd_data  = cmd;
            i_cmd_valid = 1'b1;
            while (!o_cmd_ready)
            begin
                saw_not_ready = 1;
                @(negedge clk_pcie);
            end
            @(negedge clk_pcie);
            i_cmd_valid = 1'b0;
        end
    endtask

    task pop_rsp(output logic [31:0] word);
        begin
            while (!o_rsp_valid)
                @(negedge clk_pcie);
            word        = o_rsp_data;
            i_rsp_rd_en = 1'b1;
            @(negedge clk_pcie);
            i_rsp_rd_en = 1'b0;
        end
    endtask

    task push_burst;
        for (push_idx = burst_first; push_idx < burst_end; push_idx = push_idx + 1)
            push_cmd(row_cmd[push_idx]);
    endtask

    task drain_burst;
        logic [31:0] word;
        begin
            while (o_cmd_ready)             // Wait for both FIFOs to back up
                @(negedge clk_pcie);
            for (pop_idx = burst_first; pop_idx < burst_end; pop_idx = pop_idx + 1)
            begin
                pop_rsp(word);
                check_value(row_name[pop_idx], row_exp[pop_idx], word);
            end
        end
    endtask

    // ----------------------------------------
    // Management port responder
    // ----------------------------------------
    always @(negedge clk_pcie)
    begin
        if (rst)
        begin
            mgmt_done = 1'b0;
            pending   = 0;
        end
        else if (mgmt_done)
        begin
            mgmt_done = 1'b0;   // Single-cycle done
            pending   = 0;
        end
        else if (o_cfg_mgmt_rd_en || o_cfg_mgmt_wr_en)
        begin
            if (pending == 0)
            begin
                pending   = 1;
                wait_left = $random(seed) & 3;    // Done 1 to 4 cycles later
            end
            else if (wait_left > 0)
                wait_left = wait_left - 1;
            else
            begin
                if (o_cfg_mgmt_wr_en)
                begin
                    wr_count = wr_count + 1;
                    wr_data  = o_cfg_mgmt_di;
                    wr_ctrl  = {16'h0, o_cfg_mgmt_byte_en, o_cfg_mgmt_wr_rw1c_as_rw,
                                o_cfg_mgmt_wr_readonly, o_cfg_mgmt_dwaddr};
                end
                mgmt_do   = 32'hA500_0000 + {22'h0, o_cfg_mgmt_dwaddr};
                mgmt_done = 1'b1;
            end
        end
    end

    always @(posedge clk_pcie)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit)
        begin
            $display("Run timed out after %0d cycles without finishing the table", cycle_count);
            $display("CHECKS FAILED");
            $fatal(1, "Timeout");
        end
    end

    initial
    begin
        rst         = 1'b1;
        i_cmd_valid = 1'b0;
        i_cmd_data  = 64'h0;
        i_rsp_rd_en = 1'b0;
        i_pcie_id   = PCIE_ID;
        build_table();
        cycle_limit = 40 * row_count + 200;
        repeat (4) @(posedge clk_pcie);
        @(negedge clk_pcie);
        rst = 1'b0;
        @(negedge clk_pcie);

        // Idle state out of reset
        check_value("reset_cmd_ready", 32'd1, o_cmd_ready);
        check_value("reset_rsp_valid", 32'd0, o_rsp_valid);
        check_value("reset_mgmt_en", 32'd0, {o_cfg_mgmt_rd_en, o_cfg_mgmt_wr_en});

        for (r = 0; r < row_count; r = r + 1)
        begin
            case (row_kind[r])
                KIND_WRITE:
                    push_cmd(row_cmd[r]);
                KIND_READ:
                begin
                    push_cmd(row_cmd[r]);
                    pop_rsp(got_word);
                    check_value(row_name[r], row_exp[r], got_word);
                end
                KIND_POLL:
                begin
                    rd_data = 16'h0;
                    while (!rd_data[11])        // Result valid bit
                    begin
                        push_cmd(row_cmd[r]);
                        pop_rsp(got_word);
                        rd_data = {got_word[7:0], got_word[15:8]};
                    end
                    check_value(row_name[r], row_exp[r], got_word);
                end
                KIND_WRCHK:
                begin
                    check_value({row_name[r], "_count"}, 32'd1, wr_count);
                    check_value({row_name[r], "_data"}, row_exp[r], wr_data);
                    check_value({row_name[r], "_ctrl"}, row_aux[r], wr_ctrl);
                end
                default:
                begin
                    burst_first = r;
                    burst_end   = r;
                    while (burst_end < row_count && row_kind[burst_end] == KIND_BURST)
                        burst_end = burst_end + 1;
                    saw_not_ready = 0;
                    fork
                        push_burst();
                        drain_burst();
                    join
                    check_value("burst_cmd_ready_low", 32'd1, saw_not_ready);
                    r = burst_end - 1;
                end
            endcase
        end

        if (fail_count == 0)
        begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
        else
        begin
            $display("CHECKS FAILED");
            $fatal(1, "Mismatches seen");
        end
    end

endmodule

`default_nettype wire

/* design/pcie_cfg_regs.sv */
// PCIe configuration control block, top level
// Command FIFO -> decoder -> register file -> response FIFO, with the
// management sequencer hanging off the register file.
`timescale 1ns/10ps
`default_nettype none

module pcie_cfg_regs #(
    parameter int CMD_DEPTH_LOG2 = cfg_pkg::FIFO_DEPTH_LOG2,
    parameter int RSP_DEPTH_LOG2 = cfg_pkg::FIFO_DEPTH_LOG2
) (
    input  wire logic                         clk_pcie,
    input  wire logic                         rst,
    input  wire logic                         i_cmd_valid,
    input  wire cfg_pkg::cmd_word_t           i_cmd_data,
    output logic                              o_cmd_ready,
    output logic                              o_rsp_valid,
    output cfg_pkg::rsp_word_t                o_rsp_data,
    input  wire logic                         i_rsp_rd_en,
    input  wire logic [15:0]                  i_pcie_id,
    output logic                              o_cfg_mgmt_rd_en,
    output logic                              o_cfg_mgmt_wr_en,
    input  wire logic                         i_cfg_mgmt_rd_wr_done,
    input  wire logic [31:0]                  i_cfg_mgmt_do,
    output logic [31:0]                       o_cfg_mgmt_di,
    output logic [cfg_pkg::DWADDR_W-1:0]      o_cfg_mgmt_dwaddr,
    output logic [3:0]                        o_cfg_mgmt_byte_en,
    output logic                              o_cfg_mgmt_wr_readonly,
    output logic                              o_cfg_mgmt_wr_rw1c_as_rw
);

    import cfg_pkg::*;

    cmd_word_t           cmd_head;
    rsp_word_t           rsp_word;
    logic                cmd_empty;
    logic                cmd_full;
    logic                cmd_rd_en;
    logic                rsp_empty;
    logic                rsp_almost_full;
    logic                rsp_push;
    logic                rd_stb;
    logic                wr_stb;
    logic                map_rw;
    logic                hold;
    logic [15:0]         byte_addr;
    logic [15:0]         bit_addr;
    logic [15:0]         mask;
    logic [15:0]         value;
    logic                rd_req;
    logic                wr_req;
    logic                rd_taken;
    logic                wr_taken;
    logic                rd_busy;
    logic                wr_busy;
    logic [31:0]         result_data;
    logic [DWADDR_W-1:0] result_addr;
    logic                result_valid;
    logic [3:0]          result_byte_en;

    assign o_cmd_ready = ~cmd_full;
    assign o_rsp_valid = ~rsp_empty;

    cfg_sync_fifo #(.payload_t(cmd_word_t), .DEPTH_LOG2(CMD_DEPTH_LOG2)) cmd_fifo_inst (
        .clk_pcie(clk_pcie), .rst(rst), .i_wr_en(i_cmd_valid), .i_rd_en(cmd_rd_en),
        .i_data(i_cmd_data), .o_data(cmd_head), .o_empty(cmd_empty), .o_full(cmd_full),
        .o_almost_full()
    );

    cfg_cmd_decode cmd_decode_inst (
        .clk_pcie(clk_pcie), .rst(rst), .i_fifo_empty(cmd_empty),
        .i_rsp_almost_full(rsp_almost_full), .i_hold(hold), .i_cmd(cmd_head),
        .o_fifo_rd_en(cmd_rd_en), .o_rd_stb(rd_stb), .o_wr_stb(wr_stb), .o_map_rw(map_rw),
        .o_byte_addr(byte_addr), .o_bit_addr(bit_addr), .o_mask(mask), .o_value(value)
    );

    cfg_reg_file reg_file_inst (
        .clk_pcie(clk_pcie), .rst(rst), .i_rd_stb(rd_stb), .i_wr_stb(wr_stb),
        .i_map_rw(map_rw), .i_byte_addr(byte_addr), .i_bit_addr(bit_addr),
        .i_mask(mask), .i_value(value), .i_rd_taken(rd_taken), .i_wr_taken(wr_taken),
        .i_rd_busy(rd_busy), .i_wr_busy(wr_busy), .i_result_data(result_data),
        .i_result_addr(result_addr), .i_result_valid(result_valid),
        .i_result_byte_en(result_byte_en), .i_pcie_id(i_pcie_id),
        .o_rsp_push(rsp_push), .o_rsp_word(rsp_word), .o_hold(hold),
        .o_rd_req(rd_req), .o_wr_req(wr_req), .o_mgmt_di(o_cfg_mgmt_di),
        .o_mgmt_dwaddr(o_cfg_mgmt_dwaddr), .o_mgmt_byte_en(o_cfg_mgmt_byte_en),
        .o_mgmt_wr_readonly(o_cfg_mgmt_wr_readonly),
        .o_mgmt_wr_rw1c_as_rw(o_cfg_mgmt_wr_rw1c_as_rw)
    );

    cfg_mgmt_seq mgmt_seq_inst (
        .clk_pcie(clk_pcie), .rst(rst), .i_rd_req(rd_req), .i_wr_req(wr_req),
        .i_done(i_cfg_mgmt_rd_wr_done), .i_do(i_cfg_mgmt_do),
        .i_dwaddr(o_cfg_mgmt_dwaddr), .i_byte_en(o_cfg_mgmt_byte_en),
        .o_rd_taken(rd_taken), .o_wr_taken(wr_taken), .o_rd_busy(rd_busy),
        .o_wr_busy(wr_busy), .o_cfg_mgmt_rd_en(o_cfg_mgmt_rd_en),
        .o_cfg_mgmt_wr_en(o_cfg_mgmt_wr_en), .o_result_data(result_data),
        .o_result_addr(result_addr), .o_result_valid(result_valid),
        .o_result_byte_en(result_byte_en)
    );

    cfg_sync_fifo #(.payload_t(rsp_word_t), .DEPTH_LOG2(RSP_DEPTH_LOG2)) rsp_fifo_inst (
        .clk_pcie(clk_pcie), .rst(rst), .i_wr_en(rsp_push), .i_rd_en(i_rsp_rd_en),
        .i_data(rsp_word), .o_data(o_rsp_data), .o_empty(rsp_empty), .o_full(),
        .o_almost_full(rsp_almost_full)
    );

endmodule

`default_nettype wire

/* design/cfg_mgmt_seq.sv */
// Management port sequencer
// Takes read or write request bits from the register file, holds the
// core's enable until done, and captures the completion.
`timescale 1ns/10ps
`default_nettype none

module cfg_mgmt_seq (
    input  wire logic                         clk_pcie,
    input  wire logic                         rst,
    input  wire logic                         i_rd_req,
    input  wire logic                         i_wr_req,
    input  wire logic                         i_done,
    input  wire logic [31:0]                  i_do,
    input  wire logic [cfg_pkg::DWADDR_W-1:0] i_dwaddr,
    input  wire logic [3:0]                   i_byte_en,
    output logic                              o_rd_taken,
    output logic                              o_wr_taken,
    output logic                              o_rd_busy,
    output logic                              o_wr_busy,
    output logic                              o_cfg_mgmt_rd_en,
    output logic                              o_cfg_mgmt_wr_en,
    output logic [31:0]                       o_result_data,
    output logic [cfg_pkg::DWADDR_W-1:0]      o_result_addr,
    output logic                              o_result_valid,
    output logic [3:0]                        o_result_byte_en
);

    logic idle;

    // One access on the port at a time
    assign idle       = ~o_rd_busy & ~o_wr_busy;
    assign o_rd_taken = idle & ~i_done & i_rd_req;
    assign o_wr_taken = idle & ~i_done & ~i_rd_req & i_wr_req;   // Read wins

    always_ff @(posedge clk_pcie)
    begin
        if (rst)
        begin
            o_rd_busy        <= 1'b0;
            o_wr_busy        <= 1'b0;
            o_result_valid   <= 1'b0;
            o_result_data    <= '0;
            o_result_addr    <= '0;
            o_result_byte_en <= '0;
        end
        else if (i_done)
        begin
            o_rd_busy        <= 1'b0;
            o_wr_busy        <= 1'b0;
            o_result_valid   <= 1'b1;
            o_result_data    <= i_do;
            o_result_addr    <= i_dwaddr;
            o_result_byte_en <= i_byte_en;
        end
        else if (o_rd_taken)
        begin
            o_rd_busy      <= 1'b1;
            o_result_valid <= 1'b0;
        end
        else if (o_wr_taken)
        begin
            o_wr_busy      <= 1'b1;
            o_result_valid <= 1'b0;
        end
    end

    // Enables drop in the done cycle
    assign o_cfg_mgmt_rd_en = o_rd_busy & ~i_done;
    assign o_cfg_mgmt_wr_en = o_wr_busy & ~i_done;

endmodule

`default_nettype wire

/* design/cfg_reg_file.sv */
// Configuration register file
// Holds the read-write map, builds the read-only map from live status,
// applies masked writes and answers reads with a response word.
// Request bits in the read-write map drive the management sequencer.
`timescale 1ns/10ps
`default_nettype none

module cfg_reg_file (
    input  wire logic                         clk_pcie,
    input  wire logic                         rst,
    input  wire logic                         i_rd_stb,
    input  wire logic                         i_wr_stb,
    input  wire logic                         i_map_rw,
    input  wire logic [15:0]                  i_byte_addr,
    input  wire logic [15:0]                  i_bit_addr,
    input  wire logic [15:0]                  i_mask,
    input  wire logic [15:0]                  i_value,
    input  wire logic                         i_rd_taken,
    input  wire logic                         i_wr_taken,
    input  wire logic                         i_rd_busy,
    input  wire logic                         i_wr_busy,
    input  wire logic [31:0]                  i_result_data,
    input  wire logic [cfg_pkg::DWADDR_W-1:0] i_result_addr,
    input  wire logic                         i_result_valid,
    input  wire logic [3:0]                   i_result_byte_en,
    input  wire logic [15:0]                  i_pcie_id,
    output logic                              o_rsp_push,
    output cfg_pkg::rsp_word_t                o_rsp_word,
    output logic                              o_hold,
    output logic                              o_rd_req,
    output logic                              o_wr_req,
    output logic [31:0]                       o_mgmt_di,
    output logic [cfg_pkg::DWADDR_W-1:0]      o_mgmt_dwaddr,
    output logic [3:0]                        o_mgmt_byte_en,
    output logic                              o_mgmt_wr_readonly,
    output logic                              o_mgmt_wr_rw1c_as_rw
);

    import cfg_pkg::*;

    logic [RW_BITS-1:0] rw;
    logic [RO_BITS-1:0] ro;
    logic [RW_BITS-1:0] rw_window;
    logic [RO_BITS-1:0] ro_window;
    logic [RW_BITS-1:0] wr_mask;
    logic [RW_BITS-1:0] wr_bits;
    logic [15:0]        rd_data;

    // ----------------------------------------
    // Read-only map
    // ----------------------------------------
    always_comb
    begin
        ro                                = '0;
        ro[15:0]                          = RO_MAGIC;
        ro[POS_RD_BUSY]                   = i_rd_busy;
        ro[POS_WR_BUSY]                   = i_wr_busy;
        ro[POS_RO_BYTECOUNT +: 32]        = 32'(RO_BITS / 8);
        ro[POS_RES_DATA +: 32]            = i_result_data;
        ro[POS_RES_ADDR +: DWADDR_W]      = i_result_addr;
        ro[POS_RES_VALID]                 = i_result_valid;
        ro[POS_RES_BYTE_EN +: 4]          = i_result_byte_en;
        ro[POS_PCIE_ID +: 16]             = i_pcie_id;
    end

    // Shifting past the end of a map leaves zero
    assign rw_window = rw >> i_bit_addr;
    assign ro_window = ro >> i_bit_addr;
    assign rd_data   = i_map_rw ? rw_window[15:0] : ro_window[15:0];

    // Masked write placed at the window
    assign wr_mask = {{(RW_BITS - 16){1'b0}}, i_mask} << i_bit_addr;
    assign wr_bits = {{(RW_BITS - 16){1'b0}}, i_value} << i_bit_addr;

    always_ff @(posedge clk_pcie)
    begin
        if (rst)
            rw <= RW_RESET;
        else
        begin
            if (i_wr_stb)
                rw <= (rw & ~wr_mask) | (wr_bits & wr_mask);
            if (i_rd_taken)
                rw[POS_RD_REQ] <= 1'b0;     // Sequencer owns it now
            if (i_wr_taken)
                rw[POS_WR_REQ] <= 1'b0;
        end
    end

    // ----------------------------------------
    // Response
    // ----------------------------------------
    always_ff @(posedge clk_pcie)
    begin
        if (rst)
            o_rsp_push <= 1'b0;
        else
            o_rsp_push <= i_rd_stb;
    end

    always_ff @(posedge clk_pcie)
    begin
        if (i_rd_stb)
            o_rsp_word <= {i_byte_addr, rd_data[7:0], rd_data[15:8]};
    end

    assign o_rd_req = rw[POS_RD_REQ];
    assign o_wr_req = rw[POS_WR_REQ];
    assign o_hold   = rw[POS_WAIT_COMPLETE]
                      & (o_rd_req | o_wr_req | i_rd_busy | i_wr_busy);

    assign o_mgmt_di            = rw[POS_MGMT_DI +: 32];
    assign o_mgmt_dwaddr        = rw[POS_MGMT_DWADDR +: DWADDR_W];
    assign o_mgmt_byte_en       = rw[POS_MGMT_BYTE_EN +: 4];
    assign o_mgmt_wr_readonly   = rw[POS_WR_READONLY];
    assign o_mgmt_wr_rw1c_as_rw = rw[POS_WR_RW1C_AS_RW];

endmodule

`default_nettype wire

/* design/cfg_cmd_decode.sv */
// Command decoder
// Pops the command FIFO on alternate cycles when there is room for a
// response, and turns the head word into read and write strobes with
// unswapped mask and value fields.
`timescale 1ns/10ps
`default_nettype none

module cfg_cmd_decode (
    input  wire logic               clk_pcie,
    input  wire logic               rst,
    input  wire logic               i_fifo_empty,
    input  wire logic               i_rsp_almost_full,
    input  wire logic               i_hold,
    input  wire cfg_pkg::cmd_word_t i_cmd,
    output logic                    o_fifo_rd_en,
    output logic                    o_rd_stb,
    output logic                    o_wr_stb,
    output logic                    o_map_rw,
    output logic [15:0]             o_byte_addr,
    output logic [15:0]             o_bit_addr,
    output logic [15:0]             o_mask,
    output logic [15:0]             o_value
);

    logic        pace;          // Pacing toggle
    logic [1:0]  cmd_type;      // Write, read
    logic [15:0] byte_addr;

    always_ff @(posedge clk_pcie)
    begin
        if (rst)
            pace <= 1'b0;
        else
            pace <= ~pace;
    end

    assign cmd_type  = i_cmd[13:12];
    assign byte_addr = i_cmd[31:16];

    // One pop every second cycle at most, so a request bit set by a
    // write is seen before the next command
    assign o_fifo_rd_en = pace & ~i_fifo_empty & ~i_rsp_almost_full & ~i_hold;

    assign o_rd_stb    = o_fifo_rd_en & cmd_type[0];
    assign o_wr_stb    = o_fifo_rd_en & cmd_type[1] & byte_addr[15]; // RW map only
    assign o_map_rw    = byte_addr[15];
    assign o_byte_addr = byte_addr;

    // Far addresses clamp so they still fall outside both maps
    assign o_bit_addr = (byte_addr[14:13] != 2'b00) ? 16'hffff
                                                    : {byte_addr[12:0], 3'b000};

    // Byte-swapped on the wire
    assign o_mask  = {i_cmd[39:32], i_cmd[47:40]};
    assign o_value = {i_cmd[55:48], i_cmd[63:56]};

endmodule

`default_nettype wire

/* design/cfg_sync_fifo.sv */
// Synchronous first-word-fall-through FIFO
// The head entry sits on o_data whenever the FIFO is not empty.
// Writes while full and reads while empty are dropped.
`timescale 1ns/10ps
`default_nettype none

module cfg_sync_fifo #(
    parameter type payload_t  = logic [31:0],
    parameter int  DEPTH_LOG2 = cfg_pkg::FIFO_DEPTH_LOG2
) (
    input  wire logic     clk_pcie,
    input  wire logic     rst,
    input  wire logic     i_wr_en,
    input  wire logic     i_rd_en,
    input  wire payload_t i_data,
    output payload_t      o_data,
    output logic          o_empty,
    output logic          o_full,
    output logic          o_almost_full
);

    localparam int DEPTH = 1 << DEPTH_LOG2;

    payload_t            mem [DEPTH];
    logic [DEPTH_LOG2:0] wr_ptr;    // Top bit tells full from empty
    logic [DEPTH_LOG2:0] rd_ptr;
    logic [DEPTH_LOG2:0] count;
    logic                do_wr;
    logic                do_rd;

    assign count         = wr_ptr - rd_ptr;
    assign o_empty       = (count == '0);
    assign o_full        = (count == (DEPTH_LOG2 + 1)'(DEPTH));
    assign o_almost_full = (count >= (DEPTH_LOG2 + 1)'(DEPTH - 2)); // Two or fewer free

    assign do_wr  = i_wr_en & ~o_full;
    assign do_rd  = i_rd_en & ~o_empty;
    assign o_data = mem[rd_ptr[DEPTH_LOG2-1:0]];

    always_ff @(posedge clk_pcie)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Storage
    always_ff @(posedge clk_pcie)
    begin
        if (do_wr)
            mem[wr_ptr[DEPTH_LOG2-1:0]] <= i_data;
    end

endmodule

`default_nettype wire

/* design/cfg_pkg.sv */
// Configuration register block definitions
// Word widths, map sizes, field positions in both register maps
// and the reset image of the read-write map
`default_nettype none

package cfg_pkg;

    // ----------------------------------------
    // Word formats
    // ----------------------------------------
    localparam int CMD_W = 64;
    localparam int RSP_W = 32;

    typedef logic [CMD_W-1:0] cmd_word_t;
    typedef logic [RSP_W-1:0] rsp_word_t;

    localparam int DWADDR_W        = 10;   // Management dword address
    localparam int FIFO_DEPTH_LOG2 = 4;

    // Map sizes in bits
    localparam int RW_BITS = 128;
    localparam int RO_BITS = 128;

    localparam logic [15:0] RW_MAGIC = 16'h6745;
    localparam logic [15:0] RO_MAGIC = 16'h2301;

    // ----------------------------------------
    // Read-write map
    // ----------------------------------------
    localparam int POS_RD_REQ        = 16;
    localparam int POS_WR_REQ        = 17;
    localparam int POS_WAIT_COMPLETE = 18;
    localparam int POS_MGMT_DI       = 64;    // Byte 8
    localparam int POS_MGMT_DWADDR   = 96;    // Byte 12
    localparam int POS_WR_READONLY   = 106;
    localparam int POS_WR_RW1C_AS_RW = 107;
    localparam int POS_MGMT_BYTE_EN  = 108;

    localparam logic [RW_BITS-1:0] RW_RESET = {
        16'h0000,                  // Spare
        4'hf,                      // Byte enables
        12'h000,                   // Flags and dword address
        32'h0000_0000,             // Management write data
        32'(RW_BITS / 8),          // Byte count
        16'h0000,                  // Control bits
        RW_MAGIC
    };

    // ----------------------------------------
    // Read-only map
    // ----------------------------------------
    localparam int POS_RD_BUSY      = 16;
    localparam int POS_WR_BUSY      = 17;
    localparam int POS_RO_BYTECOUNT = 32;
    localparam int POS_RES_DATA     = 64;
    localparam int POS_RES_ADDR     = 96;
    localparam int POS_RES_VALID    = 107;
    localparam int POS_RES_BYTE_EN  = 108;
    localparam int POS_PCIE_ID      = 112;

endpackage

`default_nettype wire
